/* Bender.yml */
package:
  name: alut

export_include_dirs:
  - include

sources:
  - files:
      - hw/alut_pkg.sv
      - hw/alut_age_checker.sv
      - hw/alut_mem.sv
      - hw/alut_host_if.sv
      - hw/alut_addr_checker.sv
      - hw/alut_top.sv
  - target: simulation
    files:
      - tb/alut_assertions.sv
      - tb/alut_tb.sv

/* all.f */
+incdir+include
hw/alut_pkg.sv
hw/alut_age_checker.sv
hw/alut_mem.sv
hw/alut_host_if.sv
hw/alut_addr_checker.sv
hw/alut_top.sv
tb/alut_assertions.sv
tb/alut_tb.sv

/* hw/alut_addr_checker.sv */
//------------------------------------------------------------
// destination lookup and source learning FSM
// memory read data is expected one cycle after the address
// the age reply may take any number of cycles
// held_req must stay constant while active is high
//------------------------------------------------------------
`timescale 1ns/1ps

module alut_addr_checker import alut_pkg::*; (
   input  logic         pclk29,
   input  logic         n_p_reset29,
   input  logic         start,          // begin one lookup
   input  alut_req_t    held_req,
   input  mac_addr_t    mac_addr,       // switch own address
   input  stamp_t       curr_time,
   input  alut_entry_t  rd_entry,       // memory read data
   input  logic         age_confirmed,  // age reply strobe
   input  logic         age_ok,         // age reply result
   input  logic         clear_reused,   // read-and-clear of reused
   output logic         active,
   output port_mask_t   d_port,
   output hash_t        mem_addr,
   output logic         mem_write,
   output alut_entry_t  wr_entry,
   output logic         check_age,
   output stamp_t       last_seen,
   output logic         reused,
   output mac_addr_t    lst_inv_addr,
   output port_id_t     lst_inv_port
);

   chk_state_t  state;
   chk_state_t  state_nxt;
   hash_t       d_hash;                 // index of the destination
   hash_t       s_hash;                 // index of the source
   logic        own_hit;                // destination is the switch
   logic        entry_ok;               // dest entry valid and in date
   logic        dest_hit;
   logic        src_phase;              // memory pointed at the source
   port_mask_t  src_bit;                // mask bit of the ingress port
   port_mask_t  rd_port_bit;            // mask bit of the stored port

   // xor of the address bytes
   function automatic hash_t mac_hash(input mac_addr_t a);
      hash_t h;
      h = '0;
      for (int i = 0; i < $bits(mac_addr_t) / 8; i++)
         h ^= a[8*i +: 8];
      return h;
   endfunction

   assign d_hash  = mac_hash(held_req.d_addr);
   assign s_hash  = mac_hash(held_req.s_addr);
   assign own_hit = (held_req.d_addr == mac_addr);

   assign src_bit     = port_mask_t'(5'd1 << held_req.s_port);
   assign rd_port_bit = port_mask_t'(5'd1 << rd_entry.port);

   // ------------------------------------------------------------
   // state machine
   // ------------------------------------------------------------
   always_comb
   begin
      state_nxt = state;
      case (state)
         chk_idle:    if (start) state_nxt = chk_mac;
         chk_mac:     state_nxt = own_hit ? chk_idle : chk_rd_dest;  // nothing learned on own
         chk_rd_dest: state_nxt = chk_valid;
         chk_valid:   state_nxt = chk_age;
         chk_age:     if (age_confirmed) state_nxt = chk_addr;      // hold until reply
         chk_addr:    state_nxt = chk_rd_src;
         chk_rd_src:  state_nxt = chk_wr_src;
         chk_wr_src:  state_nxt = chk_idle;
         default:     state_nxt = chk_idle;
      endcase
   end

   always_ff @(posedge pclk29 or negedge n_p_reset29)
   begin
      if (!n_p_reset29)
         state <= chk_idle;
      else
         state <= state_nxt;
   end

   assign active = (state != chk_idle);

   // ------------------------------------------------------------
   // memory strobes
   // dest hash until the dest compare, then the source hash
   // so the source entry is back in chk_rd_src
   // ------------------------------------------------------------
   assign src_phase = (state == chk_addr) || (state == chk_rd_src) ||
                      (state == chk_wr_src);
   assign mem_addr  = src_phase ? s_hash : d_hash;
   assign mem_write = (state == chk_wr_src);

   // learned entry is always valid and stamped now
   assign wr_entry = '{valid: 1'b1, last_seen: curr_time,
                       port: held_req.s_port, mac: held_req.s_addr};

   // ------------------------------------------------------------
   // age request
   // ------------------------------------------------------------
   always_ff @(posedge pclk29 or negedge n_p_reset29)
   begin
      if (!n_p_reset29)
         check_age <= 1'b0;
      else
         check_age <= (state == chk_valid);   // one pulse per lookup
   end

   always_ff @(posedge pclk29)
   begin
      if (state == chk_valid)
         last_seen <= rd_entry.last_seen;     // dest entry is on rd_entry here
   end

   // valid bit first, then and in the age result
   always_ff @(posedge pclk29 or negedge n_p_reset29)
   begin
      if (!n_p_reset29)
         entry_ok <= 1'b0;
      else if (state == chk_valid)
         entry_ok <= rd_entry.valid;
      else if ((state == chk_age) && age_confirmed)
         entry_ok <= entry_ok & age_ok;
   end

   // rd_entry still holds the dest entry in chk_addr
   assign dest_hit = entry_ok && (rd_entry.mac == held_req.d_addr);

   // ------------------------------------------------------------
   // destination port mask
   // ------------------------------------------------------------
   always_ff @(posedge pclk29 or negedge n_p_reset29)
   begin
      if (!n_p_reset29)
         d_port <= 5'b0_1111;
      else if ((state == chk_mac) && own_hit)
         d_port <= 5'b1_0000;                           // frame for the switch
      else if (state == chk_addr)
      begin
         if (dest_hit)
            d_port <= rd_port_bit & ~src_bit;           // known port
         else
            d_port <= 5'b0_1111 & ~src_bit;             // flood, never back out
      end
   end

   // ------------------------------------------------------------
   // eviction tracking
   // a set wins over a clear in the same cycle
   // ------------------------------------------------------------
   always_ff @(posedge pclk29 or negedge n_p_reset29)
   begin
      if (!n_p_reset29)
      begin
         reused       <= 1'b0;
         lst_inv_addr <= '0;
         lst_inv_port <= '0;
      end
      else if ((state == chk_rd_src) && rd_entry.valid &&
               (rd_entry.mac != held_req.s_addr))
      begin
         reused       <= 1'b1;
         lst_inv_addr <= rd_entry.mac;                  // about to be overwritten
         lst_inv_port <= rd_entry.port;
      end
      else if (clear_reused)
         reused <= 1'b0;                                // address and port kept
   end

endmodule

/* hw/alut_age_checker.sv */
//------------------------------------------------------------
// time base and in-date check
// time wraps at 2^32 and the age difference wraps with it
// reply comes exactly one cycle after check_age
//------------------------------------------------------------
`timescale 1ns/1ps

module alut_age_checker import alut_pkg::*; (
   input  logic    pclk29,
   input  logic    n_p_reset29,
   input  logic    check_age,       // one-cycle request
   input  stamp_t  last_seen,       // stamp of the entry under test
   input  stamp_t  max_age,         // oldest allowed age, inclusive
   output stamp_t  curr_time,
   output logic    age_confirmed,   // reply strobe
   output logic    age_ok           // in date, held until next request
);

   stamp_t age;                     // time since the entry was learned

   assign age = curr_time - last_seen;   // modulo wrap is intended

   // free-running counter
   always_ff @(posedge pclk29 or negedge n_p_reset29)
   begin
      if (!n_p_reset29)
         curr_time <= '0;
      else
         curr_time <= curr_time + stamp_t'(1);
   end

   // ------------------------------------------------------------
   // reply
   // ------------------------------------------------------------
   always_ff @(posedge pclk29 or negedge n_p_reset29)
   begin
      if (!n_p_reset29)
      begin
         age_confirmed <= 1'b0;
         age_ok        <= 1'b0;
      end
      else
      begin
         age_confirmed <= check_age;
         if (check_age)
            age_ok <= (age <= max_age);
      end
   end

endmodule

/* hw/alut_host_if.sv */
//------------------------------------------------------------
// four-phase req/ack front end
// a request is taken only on a rising req with ack low
// req_data is sampled once, at that edge
// ack rises one cycle after active falls, drops after req does
//------------------------------------------------------------
`timescale 1ns/1ps

module alut_host_if import alut_pkg::*; (
   input  logic       pclk29,
   input  logic       n_p_reset29,
   input  logic       req,         // host request level
   input  alut_req_t  req_data,    // stable while req is high
   output logic       ack,         // result ready
   output logic       start,       // one-cycle kick to the checker
   output alut_req_t  held_req,    // request as seen at accept
   input  logic       active       // checker busy
);

   logic req_d;                    // req one cycle late, for edge detect
   logic active_d;                 // active one cycle late
   logic busy;                     // operation in flight
   logic accept;                   // new request taken this cycle
   logic active_fall;

   assign accept      = req & ~req_d & ~busy & ~ack;
   assign active_fall = active_d & ~active;

   // ------------------------------------------------------------
   // handshake sequencing
   // ------------------------------------------------------------
   always_ff @(posedge pclk29 or negedge n_p_reset29)
   begin
      if (!n_p_reset29)
      begin
         req_d    <= 1'b0;
         active_d <= 1'b0;
         busy     <= 1'b0;
         ack      <= 1'b0;
         start    <= 1'b0;
      end
      else
      begin
         req_d    <= req;
         active_d <= active;
         start    <= accept;           // single pulse
         if (accept)
            busy <= 1'b1;
         else if (busy && active_fall)
         begin
            busy <= 1'b0;
            ack  <= 1'b1;              // d_port settled by now
         end
         else if (ack && !req)
            ack <= 1'b0;               // host dropped req, close the cycle
      end
   end

   // request capture, payload only
   always_ff @(posedge pclk29)
   begin
      if (accept)
         held_req <= req_data;
   end

endmodule

/* hw/alut_mem.sv */
//------------------------------------------------------------
// lookup table with registered read
// read during write returns the old entry
// valid bits live in flops so reset empties the table
//------------------------------------------------------------
`timescale 1ns/1ps

`include "alut_cfg.svh"

module alut_mem import alut_pkg::*; (
   input  logic         pclk29,
   input  logic         n_p_reset29,
   input  hash_t        addr,
   input  logic         write,
   input  alut_entry_t  wr_entry,
   output alut_entry_t  rd_entry       // one cycle after addr
);

   alut_entry_t             entries_q [`ALUT_DEPTH];  // stored valid bit is ignored
   logic [`ALUT_DEPTH-1:0]  valid_q;
   alut_entry_t             rd_q;
   logic                    rd_valid;

   // payload array
   always_ff @(posedge pclk29)
   begin
      if (write)
         entries_q[addr] <= wr_entry;
      rd_q <= entries_q[addr];
   end

   // valid flops
   always_ff @(posedge pclk29 or negedge n_p_reset29)
   begin
      if (!n_p_reset29)
      begin
         valid_q  <= '0;
         rd_valid <= 1'b0;
      end
      else
      begin
         if (write)
            valid_q[addr] <= wr_entry.valid;
         rd_valid <= valid_q[addr];
      end
   end

   always_comb
   begin
      rd_entry       = rd_q;
      rd_entry.valid = rd_valid;     // flop copy overrides the array bit
   end

endmodule

/* hw/alut_pkg.sv */
//------------------------------------------------------------
// types shared by the address lookup blocks
// entry layout is valid, last seen time, port, address
// with the address in the low bits
//------------------------------------------------------------
package alut_pkg;

`include "alut_cfg.svh"

   typedef logic [`ALUT_MAC_W-1:0]          mac_addr_t;   // ethernet address
   typedef logic [1:0]                      port_id_t;    // one of four ports
   typedef logic [4:0]                      port_mask_t;  // bit 4 is the switch itself
   typedef logic [$clog2(`ALUT_DEPTH)-1:0]  hash_t;       // table index
   typedef logic [`ALUT_TIME_W-1:0]         stamp_t;      // time value

   // one table entry, 83 bits
   typedef struct packed {
      logic       valid;      // entry holds a learned address
      stamp_t     last_seen;  // time of the last learn
      port_id_t   port;       // port the address was seen on
      mac_addr_t  mac;        // learned address
   } alut_entry_t;

   // one host request, held for the whole operation
   typedef struct packed {
      mac_addr_t  d_addr;     // destination to look up
      mac_addr_t  s_addr;     // source to learn
      port_id_t   s_port;     // port the frame came in on
   } alut_req_t;

   // address checker FSM
   typedef enum logic [2:0] {
      chk_idle    = 3'd0,
      chk_mac     = 3'd1,     // own address compare
      chk_rd_dest = 3'd2,     // destination read issued
      chk_valid   = 3'd3,     // destination entry valid bit
      chk_age     = 3'd4,     // waiting on the age checker
      chk_addr    = 3'd5,     // destination address compare
      chk_rd_src  = 3'd6,     // source entry read back
      chk_wr_src  = 3'd7      // source entry write
   } chk_state_t;

endpackage

/* hw/alut_top.sv */
//------------------------------------------------------------
// address lookup subsystem
// one operation in flight, host side is four-phase req/ack
// mac_addr and max_age are treated as static
//------------------------------------------------------------
`timescale 1ns/1ps

module alut_top import alut_pkg::*; (
   input  logic        pclk29,
   input  logic        n_p_reset29,
   input  logic        req,
   input  alut_req_t   req_data,
   output logic        ack,
   output port_mask_t  d_port,
   input  mac_addr_t   mac_addr,       // switch own address
   input  stamp_t      max_age,
   input  logic        clear_reused,   // one-cycle pulse
   output logic        reused,
   output mac_addr_t   lst_inv_addr,
   output port_id_t    lst_inv_port
);

   logic         start;
   logic         active;
   alut_req_t    held_req;
   hash_t        mem_addr;
   logic         mem_write;
   alut_entry_t  wr_entry;
   alut_entry_t  rd_entry;
   logic         check_age;
   logic         age_confirmed;
   logic         age_ok;
   stamp_t       last_seen;
   stamp_t       curr_time;

   alut_host_if u_host_if (
      .pclk29, .n_p_reset29, .req, .req_data, .ack,
      .start, .held_req, .active
   );

   alut_addr_checker u_addr_checker (
      .pclk29, .n_p_reset29, .start, .held_req, .mac_addr, .curr_time,
      .rd_entry, .age_confirmed, .age_ok, .clear_reused, .active, .d_port,
      .mem_addr, .mem_write, .wr_entry, .check_age, .last_seen,
      .reused, .lst_inv_addr, .lst_inv_port
   );

   alut_age_checker u_age_checker (
      .pclk29, .n_p_reset29, .check_age, .last_seen, .max_age,
      .curr_time, .age_confirmed, .age_ok
   );

   alut_mem u_mem (
      .pclk29, .n_p_reset29, .addr(mem_addr), .write(mem_write),
      .wr_entry, .rd_entry
   );

endmodule

/* include/alut_cfg.svh */
//------------------------------------------------------------
// table geometry and field widths for the address lookup
// the hash folds the address bytes into 8 bits
// so depth has to stay at 256 entries
//------------------------------------------------------------
`ifndef ALUT_CFG_SVH
`define ALUT_CFG_SVH

// table entries, one per hash value
`define ALUT_DEPTH  256

// ethernet mac address width
`define ALUT_MAC_W  48

// width of the free-running time counter and stored stamps
`define ALUT_TIME_W 32

`endif

/* tb/alut_assertions.sv */
//------------------------------------------------------------
// handshake and port mask properties, bound into alut_top
// sampled on the rising clock and idle during reset
//------------------------------------------------------------
`timescale 1ns/1ps

module alut_assertions import alut_pkg::*; (
   input logic        pclk29,
   input logic        n_p_reset29,
   input logic        req,
   input alut_req_t   req_data,
   input logic        ack,
   input port_mask_t  d_port
);

   int failures = 0;   // failed property count

   // ack only answers a pending request
   ack_needs_req: assert property (@(posedge pclk29) disable iff (!n_p_reset29)
      $rose(ack) |-> req)
      else
      begin
         $error("ack rose while req was low");
         failures++;
      end

   // host keeps the payload still for the whole request
   req_data_stable: assert property (@(posedge pclk29) disable iff (!n_p_reset29)
      (req && $past(req)) |-> $stable(req_data))
      else
      begin
         $error("req_data changed while req was high");
         failures++;
      end

   // own address is never mixed with an ethernet port
   own_mask_alone: assert property (@(posedge pclk29) disable iff (!n_p_reset29)
      d_port[4] |-> (d_port[3:0] == 4'b0000))
      else
      begin
         $error("d_port has bit 4 together with a port bit");
         failures++;
      end

endmodule

bind alut_top alut_assertions u_alut_assertions (.*);

/* tb/alut_cases.txt */
# name d_addr s_addr s_port max_age | expected: d_port(bin) reused inv_addr inv_port
# last column set to 1 pulses clear_reused after the case; own mac is 0200000000aa
own_addr    0200000000aa 000000000011 1 0000ffff 10000 0 000000000000 0 0
flood_empty 001122334455 00000000000a 2 0000ffff 01011 0 000000000000 0 0
hit_port2   00000000000a 00000000000b 0 0000ffff 00100 0 000000000000 0 0
aged_out    00000000000a 00000000000b 0 00000000 01110 0 000000000000 0 0
collide     0000000000ff 00000000010b 3 0000ffff 00111 1 00000000000a 2 0
own_keeps   0200000000aa 000000000022 0 0000ffff 10000 1 00000000000a 2 1
hit_port3   00000000010b 00000000000c 1 0000ffff 01000 0 00000000000a 2 0
evicted     00000000000a 00000000000d 0 0000ffff 01110 0 00000000000a 2 0
same_port   00000000010b 00000000010b 3 0000ffff 00000 0 00000000000a 2 0
recollide   0000000000ff 00000000000a 1 0000ffff 01101 1 00000000010b 3 1

/* tb/alut_tb.sv */
//------------------------------------------------------------
// testbench for the address lookup subsystem
// cases are read from tb/alut_cases.txt relative to the project root
// one request in flight and every ack wait bounded by a timeout
// outputs are sampled on the falling clock edge
//------------------------------------------------------------
`timescale 1ns/1ps

module alut_tb import alut_pkg::*; ();

   localparam int        TIMEOUT_CYCLES = 200;              // per ack edge
   localparam mac_addr_t OWN_MAC        = 48'h0200_0000_00aa;

   logic        pclk29;
   logic        n_p_reset29;
   logic        req;
   alut_req_t   req_data;
   logic        ack;
   port_mask_t  d_port;
   mac_addr_t   mac_addr;
   stamp_t      max_age;
   logic        clear_reused;
   logic        reused;
   mac_addr_t   lst_inv_addr;
   port_id_t    lst_inv_port;

   int          mismatches;
   int          timeouts;
   int          other_errors;
   int          assert_fails;  // failed bound properties
   int          n_cases;
   logic        timed_out;     // stops the case loop

   alut_top DUT (.*);

   initial
   begin
      pclk29 = 1'b0;
      forever #10 pclk29 = ~pclk29;   // 20 ns period
   end

   // ------------------------------------------------------------
   // compare tasks by result type
   // ------------------------------------------------------------
   task automatic check_mask(input string name, input port_mask_t exp, input port_mask_t act);
      if (act !== exp)
      begin
         mismatches++;
         $display("mismatch %s d_port expected %b actual %b", name, exp, act);
      end
   endtask

   task automatic check_flag(input string name, input string sig, input logic exp,
                             input logic act);
      if (act !== exp)
      begin
         mismatches++;
         $display("mismatch %s %s expected %b actual %b", name, sig, exp, act);
      end
   endtask

   task automatic check_mac(input string name, input mac_addr_t exp, input mac_addr_t act);
      if (act !== exp)
      begin
         mismatches++;
         $display("mismatch %s lst_inv_addr expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_port(input string name, input port_id_t exp, input port_id_t act);
      if (act !== exp)
      begin
         mismatches++;
         $display("mismatch %s lst_inv_port expected %0d actual %0d", name, exp, act);
      end
   endtask

   // ------------------------------------------------------------
   // handshake helpers
   // ------------------------------------------------------------
   task automatic wait_ack(input logic level, input string name);
      int cycles;
      cycles = 0;
      @(negedge pclk29);
      while ((ack !== level) && (cycles < TIMEOUT_CYCLES))
      begin
         @(negedge pclk29);
         cycles++;
      end
      if (ack !== level)
      begin
         timeouts++;
         timed_out = 1'b1;
         $display("%s: ack never went to %b within %0d cycles", name, level, TIMEOUT_CYCLES);
      end
   endtask

   // one-cycle read-and-clear pulse and reused must drop right after
   task automatic pulse_clear(input string name);
      @(posedge pclk29);
      clear_reused <= 1'b1;
      @(posedge pclk29);
      clear_reused <= 1'b0;
      @(negedge pclk29);
      check_flag(name, "reused after clear", 1'b0, reused);
   endtask

   task automatic run_case(input string name, input alut_req_t rq, input stamp_t age,
                           input port_mask_t exp_mask, input logic exp_reused,
                           input mac_addr_t exp_addr, input port_id_t exp_port,
                           input logic do_clear);
      @(posedge pclk29);
      req_data <= rq;
      max_age  <= age;
      req      <= 1'b1;
      wait_ack(1'b1, name);
      if (timed_out)
         return;
      check_mask(name, exp_mask, d_port);            // result valid while ack high
      check_flag(name, "reused", exp_reused, reused);
      check_mac(name, exp_addr, lst_inv_addr);
      check_port(name, exp_port, lst_inv_port);
      @(posedge pclk29);
      req <= 1'b0;                                   // close the four-phase cycle
      wait_ack(1'b0, name);
      if (timed_out)
         return;
      if (do_clear)
         pulse_clear(name);
   endtask

   // ------------------------------------------------------------
   // main sequence
   // ------------------------------------------------------------
   initial
   begin
      string       line;
      string       name;
      int          fd;
      int          n;
      mac_addr_t   d_addr;
      mac_addr_t   s_addr;
      port_id_t    s_port;
      stamp_t      age;
      port_mask_t  exp_mask;
      logic        exp_reused;
      mac_addr_t   exp_addr;
      port_id_t    exp_port;
      logic        do_clear;
      alut_req_t   rq;

      n_p_reset29  = 1'b0;
      req          = 1'b0;
      req_data     = '0;
      mac_addr     = OWN_MAC;     // static for the whole run
      max_age      = '0;
      clear_reused = 1'b0;
      mismatches   = 0;
      timeouts     = 0;
      other_errors = 0;
      assert_fails = 0;
      n_cases      = 0;
      timed_out    = 1'b0;

      repeat (4) @(posedge pclk29);
      n_p_reset29 <= 1'b1;
      @(negedge pclk29);
      check_mask("reset", 5'b0_1111, d_port);
      check_flag("reset", "ack", 1'b0, ack);
      check_flag("reset", "reused", 1'b0, reused);

      fd = $fopen("tb/alut_cases.txt", "r");
      if (fd == 0)
      begin
         other_errors++;
         $display("could not open the case file tb/alut_cases.txt");
      end
      else
      begin
         while (!timed_out && ($fgets(line, fd) != 0))
         begin
            if ((line.len() < 2) || (line.substr(0, 0) == "#"))
               continue;                             // blank or comment line
            n = $sscanf(line, "%s %h %h %h %h %b %h %h %h %h", name, d_addr, s_addr,
                        s_port, age, exp_mask, exp_reused, exp_addr, exp_port, do_clear);
            if (n != 10)
            begin
               other_errors++;
               $display("case line has %0d fields instead of 10: %s", n, line);
            end
            else
            begin
               n_cases++;
               rq = '{d_addr: d_addr, s_addr: s_addr, s_port: s_port};
               run_case(name, rq, age, exp_mask, exp_reused, exp_addr, exp_port, do_clear);
            end
         end
         $fclose(fd);
      end

      if (n_cases == 0)
      begin
         other_errors++;
         $display("no cases were run");
      end

      assert_fails = DUT.u_alut_assertions.failures;
      $display("cases %0d, mismatches %0d, timeouts %0d, assertions %0d, other errors %0d",
               n_cases, mismatches, timeouts, assert_fails, other_errors);
      if ((mismatches + timeouts + assert_fails + other_errors) == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

endmodule
